//--- sources.f
+incdir+hdl
hdl/pipeline_pkg.sv
hdl/icache_if.sv
hdl/icache.sv
hdl/ifetch.sv
hdl/dispatch.sv
hdl/regfile.sv
hdl/issue.sv
hdl/stage_ex.sv
hdl/pipeline.sv
dv/mem_model.sv
dv/pipeline_tb.sv

//--- Bender.yml
package:
  name: rv32i_pipeline_slice

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pipeline_pkg.sv
      - hdl/icache_if.sv
      - hdl/icache.sv
      - hdl/ifetch.sv
      - hdl/dispatch.sv
      - hdl/regfile.sv
      - hdl/issue.sv
      - hdl/stage_ex.sv
      - hdl/pipeline.sv
  - target: test
    files:
      - dv/mem_model.sv
      - dv/pipeline_tb.sv

//--- dv/pipeline_tb.sv
/*
 * Testbench for the RV32I pipeline slice.
 * Program starts at address 0 and ends in one illegal instruction.
 * Expected commits come from a reference model run over the table.
 * Inputs change and outputs are sampled 1 ns after the rising edge.
 */
`timescale 1ns/1ns

module pipeline_tb import pipeline_pkg::*; ();

    localparam int          CLOCK_PERIOD   = 20;
    localparam int          DRIVE_DELAY    = 1;
    localparam logic [31:0] SEED           = 32'he92d3fa6;
    localparam int          MEM_LINES      = 64;
    localparam int          NUM_ROWS       = 33;
    localparam int          LEGAL_ROWS     = NUM_ROWS - 1;
    localparam int          REGION_START   = 0;
    localparam int          REGION_COPY    = 20;
    localparam int          REGION_LEN     = 6;
    localparam int          DRAIN_CYCLES   = 12;
    localparam int          TIMEOUT_CYCLES = 40 * NUM_ROWS + 200;

    // RV32I encodings
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [9:0] FN_ADD        = {7'h00, 3'b000};
    localparam logic [9:0] FN_SUB        = {7'h20, 3'b000};
    localparam logic [9:0] FN_XOR        = {7'h00, 3'b100};
    localparam logic [9:0] FN_OR         = {7'h00, 3'b110};
    localparam logic [9:0] FN_AND        = {7'h00, 3'b111};

    logic            clock;
    logic            reset;
    mem_tag_t        mem2proc_response;
    mem_line_t       mem2proc_data;
    mem_tag_t        mem2proc_tag;
    mem_cmd_e        proc2mem_command;
    addr_t           proc2mem_addr;
    logic [3:0]      pipeline_completed_insts;
    exception_code_e pipeline_error_status;
    reg_idx_t        pipeline_commit_wr_idx;
    data_t           pipeline_commit_wr_data;
    logic            pipeline_commit_wr_en;
    addr_t           pipeline_commit_NPC;

    // Stimulus and expected values
    inst_t    prog_inst [NUM_ROWS];
    reg_idx_t exp_rd    [NUM_ROWS];
    data_t    exp_val   [NUM_ROWS];
    data_t    ref_regs  [32];

    int mismatches;
    int failures;
    int row;

    pipeline DUT (.*);

    mem_model #(
        .MEM_LINES   (MEM_LINES),
        .DRIVE_DELAY (DRIVE_DELAY),
        .SEED        (SEED)
    ) memory (
        .clock             (clock),
        .reset             (reset),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // Encoders and reference model
    //////////////////////////////

    function automatic inst_t r_type(input logic [9:0] fn, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, OPCODE_OP};
    endfunction

    function automatic inst_t addi(input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPCODE_OP_IMM};
    endfunction

    // ALU result as the ISA defines it
    function automatic data_t ref_result(input inst_t inst);
        data_t a;
        data_t b;
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        if (inst[6:0] == OPCODE_OP_IMM) begin
            return a + {{20{inst[31]}}, inst[31:20]};
        end
        case (inst[14:12])
            3'b000:  return inst[30] ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        int i;
        // Region run twice, built from x0 so both copies match
        prog_inst[0]  = addi(1, 0, 5);
        prog_inst[1]  = addi(2, 0, -3);
        prog_inst[2]  = r_type(FN_ADD, 3, 1, 2);
        prog_inst[3]  = r_type(FN_SUB, 4, 3, 1);
        prog_inst[4]  = r_type(FN_XOR, 5, 4, 2);
        prog_inst[5]  = r_type(FN_OR,  6, 5, 3);
        prog_inst[6]  = r_type(FN_AND, 7, 6, 1);
        // Write to x0, then read x0
        prog_inst[7]  = addi(0, 1, 123);
        prog_inst[8]  = r_type(FN_ADD, 8, 0, 1);
        prog_inst[9]  = addi(9, 0, 2047);
        prog_inst[10] = addi(10, 0, -2048);
        prog_inst[11] = r_type(FN_SUB, 11, 9, 10);
        prog_inst[12] = r_type(FN_XOR, 12, 11, 11);
        prog_inst[13] = r_type(FN_OR,  13, 12, 10);
        prog_inst[14] = r_type(FN_AND, 14, 13, 9);
        prog_inst[15] = addi(15, 14, 1);
        prog_inst[16] = r_type(FN_ADD, 16, 15, 15);
        // rd equal to both sources
        prog_inst[17] = r_type(FN_ADD, 16, 16, 16);
        prog_inst[18] = r_type(FN_SUB, 17, 0, 16);
        prog_inst[19] = addi(1, 1, 1);
        for (i = 0; i < REGION_LEN; i++) begin
            prog_inst[REGION_COPY + i] = prog_inst[REGION_START + i];
        end
        prog_inst[26] = r_type(FN_ADD, 18, 6, 17);
        prog_inst[27] = r_type(FN_XOR, 19, 18, 1);
        prog_inst[28] = addi(20, 19, -1);
        prog_inst[29] = r_type(FN_AND, 21, 20, 18);
        prog_inst[30] = r_type(FN_OR,  0, 21, 20);
        prog_inst[31] = r_type(FN_ADD, 22, 0, 21);
        // LW x1, 0(x0) is outside the supported set
        prog_inst[32] = 32'h0000_2083;

        for (i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            exp_rd[i]  = '0;
            exp_val[i] = '0;
        end
        for (i = 0; i < LEGAL_ROWS; i++) begin
            exp_rd[i]  = prog_inst[i][11:7];
            exp_val[i] = ref_result(prog_inst[i]);
            if (exp_rd[i] != 0) begin
                ref_regs[exp_rd[i]] = exp_val[i];
            end
        end
    endtask

    task automatic load_memory();
        int i;
        for (i = 0; i < NUM_ROWS; i++) begin
            memory.write_word(i, prog_inst[i]);
        end
    endtask

    //////////////////////////////
    // Checking helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic wait_for_commit();
        @(posedge clock);
        #DRIVE_DELAY;
        while (!pipeline_commit_wr_en) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
    endtask

    // One cycle in which nothing may commit
    task automatic step_without_commit();
        @(posedge clock);
        #DRIVE_DELAY;
        if (pipeline_commit_wr_en) begin
            failures++;
            $display("Commit to x%0d at %0t came after the illegal instruction",
                     pipeline_commit_wr_idx, $time);
        end
    endtask

    // Memory port stays read only and line aligned
    always @(posedge clock) begin
        #DRIVE_DELAY;
        if (!reset && proc2mem_command != BUS_NONE) begin
            if (proc2mem_command != BUS_LOAD) begin
                mismatches++;
                $display("MISMATCH proc2mem_command: got %h expected %h",
                         proc2mem_command, BUS_LOAD);
            end
            if (proc2mem_addr[2:0] != 3'b000) begin
                failures++;
                $display("Load address %h is not 64-bit aligned", proc2mem_addr);
            end
            if (proc2mem_addr >= MEM_LINES * 8) begin
                failures++;
                $display("Load address %h is outside the test memory", proc2mem_addr);
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        failures++;
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("Checks failed");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        reset      = 1'b1;
        mismatches = 0;
        failures   = 0;
        build_program();
        @(posedge clock);
        load_memory();
        @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        // State right after reset
        check_value("proc2mem_command", proc2mem_command, BUS_NONE);
        check_value("pipeline_commit_wr_en", pipeline_commit_wr_en, 1'b0);
        check_value("pipeline_completed_insts", pipeline_completed_insts, 4'd0);
        check_value("pipeline_error_status", pipeline_error_status, NO_ERROR);

        // Commits in table order, the repeated region after fresh misses
        for (row = 0; row < LEGAL_ROWS; row++) begin
            wait_for_commit();
            check_value("pipeline_commit_wr_idx", pipeline_commit_wr_idx, exp_rd[row]);
            check_value("pipeline_commit_wr_data", pipeline_commit_wr_data, exp_val[row]);
            check_value("pipeline_commit_NPC", pipeline_commit_NPC, row * 4 + 4);
            check_value("pipeline_completed_insts", pipeline_completed_insts, 4'd1);
        end

        // Illegal row raises the error and commits nothing more
        while (pipeline_error_status != ILLEGAL_INST) begin
            step_without_commit();
        end
        repeat (DRAIN_CYCLES) step_without_commit();
        check_value("pipeline_error_status", pipeline_error_status, ILLEGAL_INST);

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dv/mem_model.sv
/*
 * Read-only test memory on the tagged load port.
 * Refuses each load 0 to 2 times, then returns the line 1 to 4 cycles
 * after acceptance under a rotating nonzero tag. One load in flight.
 * Words never written hold an address pattern with an illegal opcode.
 */
`timescale 1ns/1ns

module mem_model import pipeline_pkg::*; #(
    parameter int          MEM_LINES   = 64,
    parameter int          DRIVE_DELAY = 1,
    parameter logic [31:0] SEED        = 32'he92d3fa6
) (
    input  logic      clock,
    input  logic      reset,
    input  mem_cmd_e  proc2mem_command,
    input  addr_t     proc2mem_addr,
    output mem_tag_t  mem2proc_response,
    output mem_line_t mem2proc_data,
    output mem_tag_t  mem2proc_tag
);

    localparam int LINE_IDX_W = $clog2(MEM_LINES);

    inst_t                 words [2*MEM_LINES];
    integer                seed;
    logic                  pending;
    logic                  counting;
    int                    refusals;
    int                    delay_left;
    mem_tag_t              next_tag;
    mem_tag_t              pending_tag;
    mem_line_t             pending_line;
    logic [LINE_IDX_W-1:0] line_idx;

    initial begin
        seed              = SEED;
        mem2proc_response = '0;
        mem2proc_data     = '0;
        mem2proc_tag      = '0;
        pending           = 1'b0;
        counting          = 1'b0;
        next_tag          = mem_tag_t'(1);
        // Untouched words decode as opcode 7f
        for (int i = 0; i < 2*MEM_LINES; i++) begin
            words[i] = {i[15:0] ^ 16'hc0de, 16'h007f};
        end
    end

    task automatic write_word(input int index, input inst_t value);
        words[index] = value;
    endtask

    //////////////////////////////
    // Load handshake
    //////////////////////////////

    always @(posedge clock) begin
        #DRIVE_DELAY;
        mem2proc_response = '0;
        mem2proc_tag      = '0;
        if (reset) begin
            pending  = 1'b0;
            counting = 1'b0;
            next_tag = mem_tag_t'(1);
        end else if (pending) begin
            delay_left = delay_left - 1;
            // Line goes out with the tag given at acceptance
            if (delay_left == 0) begin
                mem2proc_tag  = pending_tag;
                mem2proc_data = pending_line;
                pending       = 1'b0;
            end
        end else if (proc2mem_command == BUS_LOAD) begin
            // Refusal count picked once per request
            if (!counting) begin
                refusals = $unsigned($random(seed)) % 3;
                counting = 1'b1;
            end
            if (refusals == 0) begin
                line_idx          = proc2mem_addr[LINE_IDX_W+2:3];
                pending_line      = {words[2*line_idx+1], words[2*line_idx]};
                pending_tag       = next_tag;
                mem2proc_response = next_tag;
                next_tag          = (next_tag == '1) ? mem_tag_t'(1) : next_tag + 1'b1;
                delay_left        = 1 + $unsigned($random(seed)) % 4;
                pending           = 1'b1;
                counting          = 1'b0;
            end else begin
                refusals = refusals - 1;
            end
        end
    end

endmodule

//--- hdl/pipeline.sv
/*
 * Top level of the in-order RV32I slice.
 * Memory is read only, so no data or size goes out to it.
 * At most one commit per cycle, in program order.
 */
`timescale 1ns/1ns

module pipeline import pipeline_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  mem_tag_t        mem2proc_response,
    input  mem_line_t       mem2proc_data,
    input  mem_tag_t        mem2proc_tag,
    output mem_cmd_e        proc2mem_command,
    output addr_t           proc2mem_addr,
    output logic [3:0]      pipeline_completed_insts,
    output exception_code_e pipeline_error_status,
    output reg_idx_t        pipeline_commit_wr_idx,
    output data_t           pipeline_commit_wr_data,
    output logic            pipeline_commit_wr_en,
    output addr_t           pipeline_commit_NPC
);

    if_id_packet_t if_packet;
    id_is_packet_t id_packet;
    is_ex_packet_t is_packet;
    ex_wb_packet_t wb_packet;

    logic     stall;
    logic     halt;
    reg_idx_t rf_read_idx_1;
    reg_idx_t rf_read_idx_2;
    data_t    rf_read_out_1;
    data_t    rf_read_out_2;

    // Front end stops after an illegal instruction
    assign halt = (pipeline_error_status != NO_ERROR);

    //////////////////////////////
    // Fetch and cache
    //////////////////////////////

    icache_if icache_bus ();

    icache icache_0 (
        .clock             (clock),
        .reset             (reset),
        .cache             (icache_bus.cache),
        .mem2proc_response (mem2proc_response),
        .mem2proc_data     (mem2proc_data),
        .mem2proc_tag      (mem2proc_tag),
        .proc2mem_command  (proc2mem_command),
        .proc2mem_addr     (proc2mem_addr)
    );

    ifetch ifetch_0 (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .halt      (halt),
        .cache     (icache_bus.fetch),
        .if_packet (if_packet)
    );

    //////////////////////////////
    // Dispatch, issue, execute
    //////////////////////////////

    dispatch dispatch_0 (
        .clock        (clock),
        .reset        (reset),
        .if_packet    (if_packet),
        .wb_packet    (wb_packet),
        .stall        (stall),
        .error_status (pipeline_error_status),
        .id_packet    (id_packet)
    );

    // Written from the EX/WB packet
    regfile regfile_0 (
        .clock      (clock),
        .reset      (reset),
        .read_idx_1 (rf_read_idx_1),
        .read_idx_2 (rf_read_idx_2),
        .write_en   (wb_packet.valid),
        .write_idx  (wb_packet.rd),
        .write_data (wb_packet.result),
        .read_out_1 (rf_read_out_1),
        .read_out_2 (rf_read_out_2)
    );

    issue issue_0 (
        .clock      (clock),
        .reset      (reset),
        .id_packet  (id_packet),
        .read_idx_1 (rf_read_idx_1),
        .read_idx_2 (rf_read_idx_2),
        .read_out_1 (rf_read_out_1),
        .read_out_2 (rf_read_out_2),
        .is_packet  (is_packet)
    );

    stage_ex stage_ex_0 (
        .clock     (clock),
        .reset     (reset),
        .is_packet (is_packet),
        .wb_packet (wb_packet)
    );

    // Commit taps the writeback packet directly
    assign pipeline_commit_wr_en    = wb_packet.valid;
    assign pipeline_commit_wr_idx   = wb_packet.rd;
    assign pipeline_commit_wr_data  = wb_packet.result;
    assign pipeline_commit_NPC      = wb_packet.pc + addr_t'(4);
    assign pipeline_completed_insts = {3'b000, wb_packet.valid};

endmodule

//--- hdl/stage_ex.sv
/*
 * ALU and EX/WB register.
 * The registered packet is the commit and the register write.
 */
`timescale 1ns/1ns

module stage_ex import pipeline_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  is_ex_packet_t is_packet,
    output ex_wb_packet_t wb_packet
);

    data_t result;

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb begin
        case (is_packet.alu_op)
            ADD:     result = is_packet.opa + is_packet.opb;
            SUB:     result = is_packet.opa - is_packet.opb;
            AND:     result = is_packet.opa & is_packet.opb;
            OR:      result = is_packet.opa | is_packet.opb;
            XOR:     result = is_packet.opa ^ is_packet.opb;
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // Writeback register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_packet.valid <= 1'b0;
        end else begin
            wb_packet.valid <= is_packet.valid;
        end
    end

    always_ff @(posedge clock) begin
        wb_packet.pc     <= is_packet.pc;
        wb_packet.rd     <= is_packet.rd;
        wb_packet.result <= result;
    end

endmodule

//--- hdl/issue.sv
/*
 * Operand read and IS/EX register.
 * Register file reads are combinational off the ID/IS packet.
 */
`timescale 1ns/1ns

module issue import pipeline_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  id_is_packet_t id_packet,
    output reg_idx_t      read_idx_1,
    output reg_idx_t      read_idx_2,
    input  data_t         read_out_1,
    input  data_t         read_out_2,
    output is_ex_packet_t is_packet
);

    assign read_idx_1 = id_packet.rs1;
    assign read_idx_2 = id_packet.rs2;

    always_ff @(posedge clock) begin
        if (reset) begin
            is_packet.valid <= 1'b0;
        end else begin
            is_packet.valid <= id_packet.valid;
        end
    end

    always_ff @(posedge clock) begin
        is_packet.pc     <= id_packet.pc;
        is_packet.alu_op <= id_packet.alu_op;
        is_packet.opa    <= read_out_1;
        // Operand b from immediate for ADDI
        is_packet.opb    <= id_packet.use_imm ? id_packet.imm : read_out_2;
        is_packet.rd     <= id_packet.rd;
    end

endmodule

//--- hdl/regfile.sv
/*
 * 32 x XLEN register file, two read ports, one write port.
 * x0 reads zero. A read of the index being written sees the new data.
 */
`timescale 1ns/1ns
`include "pipeline_defs.svh"

module regfile import pipeline_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t read_idx_1,
    input  reg_idx_t read_idx_2,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  data_t    write_data,
    output data_t    read_out_1,
    output data_t    read_out_2
);

    data_t regs [`NUM_REGS];

    // Write-through bypass, never from x0
    assign read_out_1 = (write_en && write_idx != '0 && write_idx == read_idx_1) ?
                        write_data : regs[read_idx_1];
    assign read_out_2 = (write_en && write_idx != '0 && write_idx == read_idx_2) ?
                        write_data : regs[read_idx_2];

    // x0 cleared by reset and never written
    always_ff @(posedge clock) begin
        if (reset) begin
            regs[0] <= '0;
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        ((read_idx_1 == '0) |-> (read_out_1 == '0)) and
        ((read_idx_2 == '0) |-> (read_out_2 == '0)));

endmodule

//--- hdl/dispatch.sv
/*
 * Decode, busy scoreboard and ID/IS register.
 * Decodes ADD, SUB, AND, OR, XOR and ADDI. Anything else halts
 * the front end with ILLEGAL_INST. x0 is never marked busy.
 */
`timescale 1ns/1ns
`include "pipeline_defs.svh"

module dispatch import pipeline_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  if_id_packet_t   if_packet,
    input  ex_wb_packet_t   wb_packet,
    output logic            stall,
    output exception_code_e error_status,
    output id_is_packet_t   id_packet
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    data_t      imm;
    alu_op_e    alu_op;
    logic       use_imm;
    logic       illegal;

    logic [`NUM_REGS-1:0] busy;
    logic [`NUM_REGS-1:0] busy_eff;
    logic [`NUM_REGS-1:0] clear_mask;
    logic [`NUM_REGS-1:0] set_mask;
    logic                 src_busy;
    logic                 halted;
    logic                 accept;

    //////////////////////////////
    // Decode
    //////////////////////////////

    assign opcode = if_packet.inst[6:0];
    assign funct3 = if_packet.inst[14:12];
    assign funct7 = if_packet.inst[31:25];
    assign rd     = if_packet.inst[11:7];
    assign rs1    = if_packet.inst[19:15];
    // Immediate forms read no rs2
    assign rs2    = use_imm ? reg_idx_t'(0) : if_packet.inst[24:20];
    assign imm    = {{(`XLEN-12){if_packet.inst[31]}}, if_packet.inst[31:20]};

    always_comb begin
        alu_op  = ADD;
        use_imm = 1'b0;
        illegal = 1'b0;
        case (opcode)
            `OPC_OP: begin
                case ({funct7, funct3})
                    {`F7_BASE, `F3_ADD_SUB}: alu_op = ADD;
                    {`F7_SUB,  `F3_ADD_SUB}: alu_op = SUB;
                    {`F7_BASE, `F3_XOR}:     alu_op = XOR;
                    {`F7_BASE, `F3_OR}:      alu_op = OR;
                    {`F7_BASE, `F3_AND}:     alu_op = AND;
                    default:                 illegal = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                // ADDI only
                illegal = (funct3 != `F3_ADD_SUB);
            end
            default: illegal = 1'b1;
        endcase
    end

    //////////////////////////////
    // Scoreboard and stall
    //////////////////////////////

    assign halted = (error_status != NO_ERROR);

    // Writeback frees its rd in the same cycle
    assign clear_mask = wb_packet.valid ? (`NUM_REGS'(1) << wb_packet.rd) : '0;
    assign busy_eff   = busy & ~clear_mask;
    assign src_busy   = busy_eff[rs1] || busy_eff[rs2];

    // Busy rd also stalls, keeping writes in order
    assign stall  = if_packet.valid && !halted && (src_busy || busy_eff[rd]);
    assign accept = if_packet.valid && !halted && !stall && !illegal;

    assign set_mask = (accept && rd != '0) ? (`NUM_REGS'(1) << rd) : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy            <= '0;
            error_status    <= NO_ERROR;
            id_packet.valid <= 1'b0;
        end else begin
            busy            <= busy_eff | set_mask;
            id_packet.valid <= accept;
            if (if_packet.valid && !halted && !stall && illegal) begin
                error_status <= ILLEGAL_INST;
            end
        end
    end

    // Payload fields
    always_ff @(posedge clock) begin
        id_packet.pc      <= if_packet.pc;
        id_packet.alu_op  <= alu_op;
        id_packet.rs1     <= rs1;
        id_packet.rs2     <= rs2;
        id_packet.rd      <= rd;
        id_packet.use_imm <= use_imm;
        id_packet.imm     <= imm;
    end

    // An older write still in writeback is never a source of the packet in issue
    assert property (@(posedge clock) disable iff (reset)
        (id_packet.valid && wb_packet.valid && (wb_packet.rd != '0)) |->
            ((wb_packet.rd != id_packet.rs1) && (wb_packet.rd != id_packet.rs2)));

endmodule

//--- hdl/ifetch.sv
/*
 * Program counter and IF/ID register.
 * No branches, so the PC only steps by 4. Stall freezes PC and packet.
 * Halt keeps the PC but stops new packets.
 */
`timescale 1ns/1ns
`include "pipeline_defs.svh"

module ifetch import pipeline_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          stall,
    input  logic          halt,
    icache_if.fetch       cache,
    output if_id_packet_t if_packet
);

    addr_t pc;

    // PC is the cache address, held until the line hits
    assign cache.addr = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc        <= `RESET_PC;
            if_packet <= '{valid: 1'b0, pc: `RESET_PC, inst: `NOP};
        end else if (!stall) begin
            if (cache.hit && !halt) begin
                pc              <= pc + addr_t'(4);
                if_packet.valid <= 1'b1;
                if_packet.pc    <= pc;
                if_packet.inst  <= cache.data;
            end else begin
                // Bubble on miss or halt
                if_packet.valid <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/icache.sv
/*
 * Direct-mapped instruction cache of 64-bit lines, read only.
 * One miss is outstanding at a time. The memory accepts a load by
 * returning a nonzero response tag and later sends the line with that tag.
 * A refused request (zero response) is repeated the next cycle.
 */
`timescale 1ns/1ns
`include "pipeline_defs.svh"

module icache import pipeline_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    icache_if.cache   cache,
    input  mem_tag_t  mem2proc_response,
    input  mem_line_t mem2proc_data,
    input  mem_tag_t  mem2proc_tag,
    output mem_cmd_e  proc2mem_command,
    output addr_t     proc2mem_addr
);

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `XLEN - IDX_W - 3;

    icache_state_e state;

    // Line storage
    logic [`ICACHE_LINES-1:0] valid_bits;
    logic [TAG_W-1:0]         tags  [`ICACHE_LINES];
    mem_line_t                lines [`ICACHE_LINES];

    // Outstanding miss
    addr_t    miss_addr;
    mem_tag_t saved_tag;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] fill_idx;
    logic             fill;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    assign idx = cache.addr[IDX_W+2:3];
    assign tag = cache.addr[`XLEN-1:IDX_W+3];

    assign cache.hit  = valid_bits[idx] && (tags[idx] == tag);
    // Bit 2 picks the upper or lower word of the line
    assign cache.data = cache.addr[2] ? lines[idx][63:32] : lines[idx][31:0];

    //////////////////////////////
    // Miss handling
    //////////////////////////////

    assign fill_idx = miss_addr[IDX_W+2:3];
    // Line returns under the tag saved at acceptance
    assign fill     = (state == WAIT_DATA) && (mem2proc_tag == saved_tag);

    assign proc2mem_command = (state == REQUEST) ? BUS_LOAD : BUS_NONE;
    assign proc2mem_addr    = {miss_addr[`XLEN-1:3], 3'b000};

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            valid_bits <= '0;
            saved_tag  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!cache.hit) begin
                        miss_addr <= cache.addr;
                        state     <= REQUEST;
                    end
                end
                REQUEST: begin
                    // Zero response means refused
                    if (mem2proc_response != '0) begin
                        saved_tag <= mem2proc_response;
                        state     <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (fill) begin
                        valid_bits[fill_idx] <= 1'b1;
                        state                <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Data and tag arrays
    always_ff @(posedge clock) begin
        if (fill) begin
            lines[fill_idx] <= mem2proc_data;
            tags[fill_idx]  <= miss_addr[`XLEN-1:IDX_W+3];
        end
    end

    // A line under the saved tag only arrives while a fill is awaited
    assert property (@(posedge clock) disable iff (reset)
        ((state != WAIT_DATA) && (saved_tag != '0)) |-> (mem2proc_tag != saved_tag));

    // Fetch is still waiting on the same line when it arrives
    assert property (@(posedge clock) disable iff (reset)
        fill |-> (cache.addr[`XLEN-1:3] == miss_addr[`XLEN-1:3]));

endmodule

//--- hdl/icache_if.sv
/*
 * Fetch to instruction cache link.
 * The cache answers in the same cycle, and fetch holds addr until hit.
 */
`timescale 1ns/1ns

interface icache_if import pipeline_pkg::*; ();

    addr_t addr;
    inst_t data;
    logic  hit;

    // Fetch side drives the word address
    modport fetch (output addr, input data, input hit);

    // Cache side returns the word and its hit flag
    modport cache (input addr, output data, output hit);

endinterface

//--- hdl/pipeline_pkg.sv
/*
 * Types shared by all pipeline stages.
 * Packets are packed structs, and valid is their only control bit.
 */
`include "pipeline_defs.svh"

package pipeline_pkg;

    typedef logic [`XLEN-1:0]      addr_t;
    typedef logic [`XLEN-1:0]      data_t;
    typedef logic [31:0]           inst_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [`MEM_TAG_W-1:0] mem_tag_t;
    typedef logic [63:0]           mem_line_t;

    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} mem_cmd_e;

    // Cause 2 is the RISC-V illegal instruction code
    typedef enum logic [3:0] {
        NO_ERROR     = 4'd0,
        ILLEGAL_INST = 4'd2
    } exception_code_e;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} alu_op_e;

    typedef enum logic [1:0] {IDLE, REQUEST, WAIT_DATA} icache_state_e;

    //////////////////////////////
    // Stage packets
    //////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } if_id_packet_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        alu_op_e  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     use_imm;
        data_t    imm;
    } id_is_packet_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        alu_op_e  alu_op;
        data_t    opa;
        data_t    opb;
        reg_idx_t rd;
    } is_ex_packet_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        data_t    result;
    } ex_wb_packet_t;

endpackage

//--- hdl/pipeline_defs.svh
/*
 * Widths, sizes and RV32I encodings shared by the pipeline.
 * Only the OP and OP-IMM major opcodes are decoded.
 * ICACHE_LINES must be a power of two.
 */
`ifndef PIPELINE_DEFS_SVH
`define PIPELINE_DEFS_SVH

// Datapath and storage sizes
`define XLEN          32
`define NUM_REGS      32
`define ICACHE_LINES  8
`define MEM_TAG_W     4

// ADDI x0, x0, 0
`define NOP           32'h0000_0013
`define RESET_PC      32'h0000_0000

// Major opcodes
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011

// Function fields
`define F3_ADD_SUB    3'b000
`define F3_XOR        3'b100
`define F3_OR         3'b110
`define F3_AND        3'b111
`define F7_BASE       7'b0000000
`define F7_SUB        7'b0100000

`endif
